// File: logic/hit_tree_pkg.sv
`default_nettype none

package hit_tree_pkg;

    // tree shape is fixed at four leaves feeding two mid nodes and one root
    localparam int NUM_CHANNELS = 4;    // input channels

    // field widths
    localparam int WORD_WIDTH   = 36;   // full packed word
    localparam int TIME_WIDTH   = 16;   // timestamp within a frame
    localparam int ADC_WIDTH    = 16;   // hit amplitude
    localparam int CHAN_WIDTH   = 3;    // channel id

    // field positions in a packed word
    // [35] marker | [34:32] channel | [31:16] time | [15:0] adc
    localparam int MARKER_BIT   = 35;   // end-of-frame flag
    localparam int CHAN_LSB     = 32;   // channel field base
    localparam int TIME_LSB     = 16;   // timestamp field base

    // packed word as it travels through buffers and nodes
    typedef logic [WORD_WIDTH-1:0] hit_word_t;

    // hit time, compared by the merge nodes
    typedef logic [TIME_WIDTH-1:0] timestamp_t;

    // raw amplitude, carried through untouched
    typedef logic [ADC_WIDTH-1:0] adc_t;

    // source channel, also set on markers
    typedef logic [CHAN_WIDTH-1:0] channel_t;

endpackage

`default_nettype wire

// File: logic/fifo_buffer.sv
`default_nettype none

// circular buffer with 2**ADDR_WIDTH slots, one of them never used
module fifo_buffer #(
    parameter int ADDR_WIDTH = 5                        // log2 of slot count
) (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire hit_tree_pkg::hit_word_t data_i,        // write data
    input  wire                          wr_en_i,       // write strobe
    input  wire                          rd_en_i,       // read strobe
    output hit_tree_pkg::hit_word_t      data_o,        // valid cycle after read
    output logic                         empty_o,       // nothing stored
    output logic                         full_o         // no room for a write
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;             // physical slots

    hit_tree_pkg::hit_word_t mem [DEPTH];               // storage array
    logic [ADDR_WIDTH-1:0] rd_ptr_q;                    // next slot to read
    logic [ADDR_WIDTH-1:0] wr_ptr_q;                    // next slot to write
    logic [ADDR_WIDTH-1:0] count_q;                     // words held
    logic                  wr_ok;                       // write accepted
    logic                  rd_ok;                       // read accepted

    assign empty_o = (count_q == '0);
    assign full_o  = &count_q;                          // all ones means full

    // concurrent rd/wr always goes through, count stays put
    assign wr_ok = wr_en_i && (!full_o || rd_en_i);
    assign rd_ok = rd_en_i && (!empty_o || wr_en_i);

    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem[wr_ptr_q] <= data_i;                    // storage has no reset
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            data_o   <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;            // wraps on power of two
            end
            if (rd_ok) begin
                data_o   <= mem[rd_ptr_q];              // holds until next read
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + 1'b1;     // write only
                2'b01:   count_q <= count_q - 1'b1;     // read only
                default: count_q <= count_q;            // idle or both
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/hit_packer.sv
`default_nettype none

// packs one channel's hits and frame ends into words for its leaf buffer
module hit_packer #(
    parameter hit_tree_pkg::channel_t CHANNEL_ID = '0    // stamped into every word
) (
    input  wire                           clk_i,
    input  wire                           rst_i,
    input  wire                           hit_valid_i,  // hit strobe
    input  wire hit_tree_pkg::timestamp_t hit_time_i,   // hit time
    input  wire hit_tree_pkg::adc_t       hit_adc_i,    // hit amplitude
    input  wire                           frame_end_i,  // end of frame strobe
    input  wire                           full_i,       // leaf buffer full
    output logic                          wr_en_o,      // leaf write strobe
    output hit_tree_pkg::hit_word_t       data_o,       // leaf write data
    output logic [15:0]                   drop_count_o  // saturating hit loss count
);

    logic                    hit_q;                     // staged hit, resolved next cycle
    hit_tree_pkg::hit_word_t hit_word_q;                // staged hit word
    logic                    mark_pend_q;               // marker waiting for space
    hit_tree_pkg::hit_word_t hit_word;                  // word formed from inputs
    hit_tree_pkg::hit_word_t mark_word;                 // constant marker for this channel
    logic                    hit_take;                  // input hit accepted
    logic                    wr_hit;                    // staged hit written
    logic                    wr_mark;                   // pending marker written
    logic                    drop_full;                 // staged hit lost to full leaf
    logic                    drop_pend;                 // input hit lost to pending marker
    logic [1:0]              drop_inc;                  // drops this cycle
    logic [16:0]             drop_sum;                  // count plus carry

    always_comb begin
        hit_word = '0;
        hit_word[hit_tree_pkg::MARKER_BIT] = 1'b0;      // plain hit
        hit_word[hit_tree_pkg::CHAN_LSB +: hit_tree_pkg::CHAN_WIDTH] = CHANNEL_ID;
        hit_word[hit_tree_pkg::TIME_LSB +: hit_tree_pkg::TIME_WIDTH] = hit_time_i;
        hit_word[0 +: hit_tree_pkg::ADC_WIDTH] = hit_adc_i;
    end

    always_comb begin
        mark_word = '0;                                 // time and adc stay zero
        mark_word[hit_tree_pkg::MARKER_BIT] = 1'b1;
        mark_word[hit_tree_pkg::CHAN_LSB +: hit_tree_pkg::CHAN_WIDTH] = CHANNEL_ID;
    end

    assign hit_take  = hit_valid_i && !mark_pend_q;     // no hits behind a waiting marker
    assign wr_hit    = hit_q && !full_i;
    assign wr_mark   = mark_pend_q && !hit_q && !full_i; // older hit goes first
    assign wr_en_o   = wr_hit || wr_mark;
    assign data_o    = hit_q ? hit_word_q : mark_word;

    assign drop_full = hit_q && full_i;                 // a hit gets one try only
    assign drop_pend = hit_valid_i && mark_pend_q;
    assign drop_inc  = {1'b0, drop_full} + {1'b0, drop_pend};
    assign drop_sum  = {1'b0, drop_count_o} + {15'd0, drop_inc};

    always_ff @(posedge clk_i) begin
        if (hit_take) begin
            hit_word_q <= hit_word;                     // payload, no reset
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hit_q        <= 1'b0;
            mark_pend_q  <= 1'b0;
            drop_count_o <= '0;
        end else begin
            hit_q <= hit_take;                          // cleared once resolved
            if (frame_end_i) begin
                mark_pend_q <= 1'b1;                    // marker is never dropped
            end else if (wr_mark) begin
                mark_pend_q <= 1'b0;
            end
            if (drop_sum[16]) begin
                drop_count_o <= '1;                     // saturate
            end else begin
                drop_count_o <= drop_sum[15:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/merge_node.sv
`default_nettype none

// merges two time-sorted buffers into one, one word per cycle at most
module merge_node (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire                          a_empty_i,     // side a buffer empty
    input  wire hit_tree_pkg::hit_word_t a_data_i,      // side a read data
    output logic                         a_rd_en_o,     // side a read strobe
    input  wire                          b_empty_i,     // side b buffer empty
    input  wire hit_tree_pkg::hit_word_t b_data_i,      // side b read data
    output logic                         b_rd_en_o,     // side b read strobe
    input  wire                          full_i,        // downstream full
    output logic                         wr_en_o,       // downstream write strobe
    output hit_tree_pkg::hit_word_t      data_o         // downstream write data
);

    // per side head tracking
    typedef enum logic [1:0] {
        SIDE_FREE,                                      // head empty, nothing in flight
        SIDE_FETCH,                                     // read issued, data lands this cycle
        SIDE_HELD                                       // head register valid
    } side_state_t;

    side_state_t              state_q [2];              // index 0 is side a
    hit_tree_pkg::hit_word_t  head_q  [2];              // prefetched head words
    logic [1:0]               side_empty;               // buffer empty per side
    hit_tree_pkg::hit_word_t  side_data [2];            // buffer read data per side
    logic [1:0]               side_rd;                  // read strobe per side
    logic [1:0]               pop;                      // head consumed this cycle
    logic                     both_held;                // both heads valid
    logic                     mark_a;                   // side a head is a marker
    logic                     mark_b;                   // side b head is a marker
    hit_tree_pkg::timestamp_t time_a;                   // side a head time
    hit_tree_pkg::timestamp_t time_b;                   // side b head time
    logic                     a_first;                  // a not later than b
    logic                     sel_b;                    // output from side b

    assign side_empty   = {b_empty_i, a_empty_i};
    assign side_data[0] = a_data_i;
    assign side_data[1] = b_data_i;
    assign a_rd_en_o    = side_rd[0];
    assign b_rd_en_o    = side_rd[1];

    assign both_held = (state_q[0] == SIDE_HELD) && (state_q[1] == SIDE_HELD);
    assign mark_a    = head_q[0][hit_tree_pkg::MARKER_BIT];
    assign mark_b    = head_q[1][hit_tree_pkg::MARKER_BIT];
    assign time_a    = head_q[0][hit_tree_pkg::TIME_LSB +: hit_tree_pkg::TIME_WIDTH];
    assign time_b    = head_q[1][hit_tree_pkg::TIME_LSB +: hit_tree_pkg::TIME_WIDTH];
    assign a_first   = (time_a <= time_b);              // tie goes to side a

    // a word only goes out once both heads are known
    assign wr_en_o = both_held && !full_i;
    assign data_o  = sel_b ? head_q[1] : head_q[0];

    // pick the outgoing head and which sides it frees
    always_comb begin
        sel_b = 1'b0;
        pop   = 2'b00;
        if (mark_a && mark_b) begin
            pop = 2'b11;                                // one merged marker, both freed
        end else if (mark_a) begin
            sel_b = 1'b1;                               // a waits at its frame end
            pop   = 2'b10;
        end else if (mark_b) begin
            pop = 2'b01;                                // b waits at its frame end
        end else if (a_first) begin
            pop = 2'b01;
        end else begin
            sel_b = 1'b1;
            pop   = 2'b10;
        end
        if (!wr_en_o) begin
            pop = 2'b00;                                // stalled or heads missing
        end
    end

    // fetch into a free head, or into one that empties this cycle
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            side_rd[s] = !side_empty[s] && ((state_q[s] == SIDE_FREE) || pop[s]);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int s = 0; s < 2; s++) begin
            if (state_q[s] == SIDE_FETCH) begin
                head_q[s] <= side_data[s];              // read data valid now
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < 2; s++) begin
                state_q[s] <= SIDE_FREE;
            end
        end else begin
            for (int s = 0; s < 2; s++) begin
                case (state_q[s])
                    SIDE_FREE: begin
                        if (side_rd[s]) begin
                            state_q[s] <= SIDE_FETCH;
                        end
                    end
                    SIDE_FETCH: begin
                        state_q[s] <= SIDE_HELD;        // captured this edge
                    end
                    SIDE_HELD: begin
                        if (pop[s]) begin
                            // refetch overlaps the write
                            state_q[s] <= side_rd[s] ? SIDE_FETCH : SIDE_FREE;
                        end
                    end
                    default: begin
                        state_q[s] <= SIDE_FREE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/hit_tree_top.sv
`default_nettype none

// four channel packers, leaf buffers, two mid merges and one root merge
module hit_tree_top #(
    parameter int LEAF_ADDR_WIDTH = 5,                  // per channel buffer depth
    parameter int NODE_ADDR_WIDTH = 5                   // mid and output buffer depth
) (
    input  wire                           clk_i,
    input  wire                           rst_i,
    input  wire [hit_tree_pkg::NUM_CHANNELS-1:0] hit_valid_i,
    input  wire hit_tree_pkg::timestamp_t hit_time_i [hit_tree_pkg::NUM_CHANNELS],
    input  wire hit_tree_pkg::adc_t       hit_adc_i  [hit_tree_pkg::NUM_CHANNELS],
    input  wire [hit_tree_pkg::NUM_CHANNELS-1:0] frame_end_i,
    input  wire                           out_rd_i,     // root buffer read strobe
    output logic                          out_empty_o,  // root buffer empty
    output hit_tree_pkg::hit_word_t       out_data_o,   // root buffer read data
    output logic [15:0]                   drop_count_o [hit_tree_pkg::NUM_CHANNELS]
);

    localparam int NUM_MID = hit_tree_pkg::NUM_CHANNELS / 2;   // mid level nodes

    // packer to leaf buffer
    logic                    leaf_wr    [hit_tree_pkg::NUM_CHANNELS];
    hit_tree_pkg::hit_word_t leaf_wdata [hit_tree_pkg::NUM_CHANNELS];
    logic                    leaf_full  [hit_tree_pkg::NUM_CHANNELS];

    // leaf buffer to mid node
    logic                    leaf_rd    [hit_tree_pkg::NUM_CHANNELS];
    logic                    leaf_empty [hit_tree_pkg::NUM_CHANNELS];
    hit_tree_pkg::hit_word_t leaf_rdata [hit_tree_pkg::NUM_CHANNELS];

    // mid node to mid buffer, then on to the root
    logic                    mid_wr    [NUM_MID];
    hit_tree_pkg::hit_word_t mid_wdata [NUM_MID];
    logic                    mid_full  [NUM_MID];
    logic                    mid_rd    [NUM_MID];
    logic                    mid_empty [NUM_MID];
    hit_tree_pkg::hit_word_t mid_rdata [NUM_MID];

    // root node to output buffer
    logic                    root_wr;
    hit_tree_pkg::hit_word_t root_wdata;
    logic                    root_full;

    for (genvar c = 0; c < hit_tree_pkg::NUM_CHANNELS; c++) begin : g_leaf
        hit_packer #(
            .CHANNEL_ID (hit_tree_pkg::channel_t'(c))   // channel id from position
        ) u_packer (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .hit_valid_i  (hit_valid_i[c]),
            .hit_time_i   (hit_time_i[c]),
            .hit_adc_i    (hit_adc_i[c]),
            .frame_end_i  (frame_end_i[c]),
            .full_i       (leaf_full[c]),
            .wr_en_o      (leaf_wr[c]),
            .data_o       (leaf_wdata[c]),
            .drop_count_o (drop_count_o[c])
        );

        fifo_buffer #(
            .ADDR_WIDTH (LEAF_ADDR_WIDTH)
        ) u_leaf_buf (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .data_i  (leaf_wdata[c]),
            .wr_en_i (leaf_wr[c]),
            .rd_en_i (leaf_rd[c]),
            .data_o  (leaf_rdata[c]),
            .empty_o (leaf_empty[c]),
            .full_o  (leaf_full[c])
        );
    end

    // mid node m merges channels 2m (side a) and 2m+1 (side b)
    for (genvar m = 0; m < NUM_MID; m++) begin : g_mid
        merge_node u_node (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .a_empty_i (leaf_empty[2*m]),
            .a_data_i  (leaf_rdata[2*m]),
            .a_rd_en_o (leaf_rd[2*m]),
            .b_empty_i (leaf_empty[2*m+1]),
            .b_data_i  (leaf_rdata[2*m+1]),
            .b_rd_en_o (leaf_rd[2*m+1]),
            .full_i    (mid_full[m]),
            .wr_en_o   (mid_wr[m]),
            .data_o    (mid_wdata[m])
        );

        fifo_buffer #(
            .ADDR_WIDTH (NODE_ADDR_WIDTH)
        ) u_mid_buf (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .data_i  (mid_wdata[m]),
            .wr_en_i (mid_wr[m]),
            .rd_en_i (mid_rd[m]),
            .data_o  (mid_rdata[m]),
            .empty_o (mid_empty[m]),
            .full_o  (mid_full[m])
        );
    end

    merge_node u_root (                                 // channels 0-1 on side a
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .a_empty_i (mid_empty[0]),
        .a_data_i  (mid_rdata[0]),
        .a_rd_en_o (mid_rd[0]),
        .b_empty_i (mid_empty[1]),
        .b_data_i  (mid_rdata[1]),
        .b_rd_en_o (mid_rd[1]),
        .full_i    (root_full),
        .wr_en_o   (root_wr),
        .data_o    (root_wdata)
    );

    fifo_buffer #(
        .ADDR_WIDTH (NODE_ADDR_WIDTH)
    ) u_out_buf (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .data_i  (root_wdata),
        .wr_en_i (root_wr),
        .rd_en_i (out_rd_i),                            // outside reader
        .data_o  (out_data_o),
        .empty_o (out_empty_o),
        .full_o  (root_full)
    );

endmodule

`default_nettype wire

// File: sim/hit_tree_ref.svh
`ifndef HIT_TREE_REF_SVH
`define HIT_TREE_REF_SVH

typedef hit_tree_pkg::hit_word_t word_q_t [$];          // ordered word sequence

word_q_t frame_q;                                        // hits of the current frame, drive order
int      slot_q [$];                                     // drive slot of each frame_q entry

// builds a hit word from its fields, marker flag clear
function automatic hit_tree_pkg::hit_word_t make_hit(
    input hit_tree_pkg::channel_t   chan,
    input hit_tree_pkg::timestamp_t t,
    input hit_tree_pkg::adc_t       adc
);
    hit_tree_pkg::hit_word_t w;
    w = '0;
    w[hit_tree_pkg::CHAN_LSB +: hit_tree_pkg::CHAN_WIDTH] = chan;
    w[hit_tree_pkg::TIME_LSB +: hit_tree_pkg::TIME_WIDTH] = t;
    w[hit_tree_pkg::ADC_WIDTH-1:0] = adc;
    return w;
endfunction

// closing word of a frame at the root, channel 0 with zero time and adc
function automatic hit_tree_pkg::hit_word_t frame_marker();
    hit_tree_pkg::hit_word_t w;
    w = '0;
    w[hit_tree_pkg::MARKER_BIT] = 1'b1;
    return w;
endfunction

// time in the upper bits, channel breaks ties
function automatic logic [hit_tree_pkg::TIME_WIDTH+hit_tree_pkg::CHAN_WIDTH-1:0] sort_key(
    input hit_tree_pkg::hit_word_t w
);
    return {w[hit_tree_pkg::TIME_LSB +: hit_tree_pkg::TIME_WIDTH],
            w[hit_tree_pkg::CHAN_LSB +: hit_tree_pkg::CHAN_WIDTH]};
endfunction

// expected root output of one frame: sorted hits, then one marker
function automatic word_q_t sorted_frame(input word_q_t hits);
    word_q_t res;
    int      j;
    res = {};
    foreach (hits[i]) begin
        j = res.size();
        while (j > 0 && sort_key(res[j-1]) > sort_key(hits[i])) begin
            j--;                                         // strict compare, same key keeps arrival order
        end
        res.insert(j, hits[i]);
    end
    res.push_back(frame_marker());
    return res;
endfunction

`endif

// File: sim/hit_tree_tb.sv
`default_nettype none

module hit_tree_tb;

    localparam int NCH = hit_tree_pkg::NUM_CHANNELS;

    `include "hit_tree_ref.svh"

    logic                     clk_i;
    logic                     rst_i;
    logic [NCH-1:0]           hit_valid_i;
    hit_tree_pkg::timestamp_t hit_time_i [NCH];
    hit_tree_pkg::adc_t       hit_adc_i  [NCH];
    logic [NCH-1:0]           frame_end_i;
    logic                     out_rd_i;
    logic                     out_empty_o;
    hit_tree_pkg::hit_word_t  out_data_o;
    logic [15:0]              drop_count_o [NCH];

    logic    drain_en;                                   // drain reads while set
    logic    timed_out;                                  // a wait gave up
    int      checks;
    int      mismatches;
    int      failures;                                   // errors other than wrong values
    word_q_t got_q;                                      // words read from the output buffer
    word_q_t exp_q;                                      // reference words not yet matched

    hit_tree_top #(
        .LEAF_ADDR_WIDTH (5),
        .NODE_ADDR_WIDTH (5)
    ) dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .hit_valid_i  (hit_valid_i),
        .hit_time_i   (hit_time_i),
        .hit_adc_i    (hit_adc_i),
        .frame_end_i  (frame_end_i),
        .out_rd_i     (out_rd_i),
        .out_empty_o  (out_empty_o),
        .out_data_o   (out_data_o),
        .drop_count_o (drop_count_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;                       // period 4
    end

    task automatic check_value(input string name,
                               input logic [hit_tree_pkg::WORD_WIDTH-1:0] expected,
                               input logic [hit_tree_pkg::WORD_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    // drain process pulls any waiting word
    initial begin
        out_rd_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (out_rd_i) begin
                got_q.push_back(out_data_o);             // read issued last rising edge
            end
            out_rd_i = drain_en && !out_empty_o;
        end
    end

    // compare process on the rising edge
    initial begin
        forever begin
            @(posedge clk_i);
            while (got_q.size() != 0) begin
                if (exp_q.size() == 0) begin
                    failures++;
                    $display("ERROR at %0t: extra output word %h", $time, got_q.pop_front());
                end else begin
                    check_value("out_data_o", exp_q.pop_front(), got_q.pop_front());
                end
            end
        end
    end

    // random frame into frame_q and slot_q
    // tie gives all channels one shared time per slot
    task automatic gen_frame(input int slots, input int pct, input int cap,
                             input bit tie, input int only_ch);
        int last_t [NCH];
        int cnt    [NCH];
        int step;
        frame_q = {};
        slot_q  = {};
        for (int c = 0; c < NCH; c++) begin
            last_t[c] = 0;
            cnt[c]    = 0;
        end
        for (int s = 0; s < slots; s++) begin
            step = int'($urandom % 4);
            for (int c = 0; c < NCH; c++) begin
                if (!tie) step = int'($urandom % 4);
                last_t[c] += step;                       // non-decreasing per channel
                if ((only_ch < 0 || only_ch == c) && cnt[c] < cap
                        && (tie || int'($urandom % 100) < pct)) begin
                    frame_q.push_back(make_hit(hit_tree_pkg::channel_t'(c),
                        hit_tree_pkg::timestamp_t'(last_t[c]), hit_tree_pkg::adc_t'($urandom)));
                    slot_q.push_back(s);
                    cnt[c]++;
                end
            end
        end
    endtask

    task automatic expect_frame(input word_q_t hits);
        word_q_t res;
        res = sorted_frame(hits);
        foreach (res[i]) exp_q.push_back(res[i]);
    endtask

    // plays frame_q slot by slot, then frame end on all channels
    task automatic drive_frame(input bit stall);
        int k;
        int s;
        int c;
        k = 0;
        s = 0;
        while (k < frame_q.size()) begin
            @(negedge clk_i);
            hit_valid_i = '0;
            if (stall) drain_en = ((s / 30) % 2) == 1;   // reads off for the first 30 slots
            while (k < frame_q.size() && slot_q[k] == s) begin
                c = int'(frame_q[k][hit_tree_pkg::CHAN_LSB +: hit_tree_pkg::CHAN_WIDTH]);
                hit_valid_i[c] = 1'b1;
                hit_time_i[c]  = frame_q[k][hit_tree_pkg::TIME_LSB +: hit_tree_pkg::TIME_WIDTH];
                hit_adc_i[c]   = frame_q[k][hit_tree_pkg::ADC_WIDTH-1:0];
                k++;
            end
            s++;
        end
        @(negedge clk_i);
        hit_valid_i = '0;
        frame_end_i = '1;                                // never with a hit
        drain_en    = 1'b1;
        @(negedge clk_i);
        frame_end_i = '0;
        @(negedge clk_i);                                // gap before next frame
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (!timed_out && (exp_q.size() != 0 || got_q.size() != 0)) begin
            @(posedge clk_i);
            n++;
            if (n > limit) begin
                timed_out = 1'b1;
                failures++;
                $display("ERROR at %0t: output stalled with %0d words still expected",
                         $time, exp_q.size());
            end
        end
    endtask

    initial begin
        word_q_t keep_q;                                 // overflow hits that fit
        rst_i = 1'b1;
        hit_valid_i = '0;
        frame_end_i = '0;
        for (int c = 0; c < NCH; c++) begin
            hit_time_i[c] = '0;
            hit_adc_i[c]  = '0;
        end
        drain_en = 1'b0;
        timed_out = 1'b0;
        checks = 0;
        mismatches = 0;
        failures = 0;
        void'($urandom(32'h2fcb49ef));
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        drain_en = 1'b1;
        gen_frame(20, 60, 30, 1'b0, 2);                  // channel 2 alone
        expect_frame(frame_q);
        drive_frame(1'b0);
        wait_drained(2000);
        repeat (4) begin                                 // random frames on all channels
            gen_frame(30, 50, 24, 1'b0, -1);
            expect_frame(frame_q);
            drive_frame(1'b0);
            wait_drained(2000);
        end
        gen_frame(10, 100, 30, 1'b1, -1);                // equal times across channels
        expect_frame(frame_q);
        drive_frame(1'b0);
        wait_drained(2000);
        repeat (3) begin                                 // back to back frames drained at the end
            gen_frame(12, 40, 8, 1'b0, -1);
            expect_frame(frame_q);
            drive_frame(1'b0);
        end
        wait_drained(3000);
        gen_frame(40, 50, 28, 1'b0, -1);                 // output stalls mid frame
        expect_frame(frame_q);
        drive_frame(1'b1);
        wait_drained(3000);
        for (int c = 0; c < NCH; c++) begin
            check_value($sformatf("drop_count_o[%0d]", c), '0, drop_count_o[c]);
        end
        drain_en = 1'b0;                                 // overflow with reads held off
        frame_q = {};
        slot_q  = {};
        keep_q  = {};
        for (int i = 0; i < 40; i++) begin
            frame_q.push_back(make_hit(3'd0, hit_tree_pkg::timestamp_t'(i),
                                       hit_tree_pkg::adc_t'($urandom)));
            slot_q.push_back(2 * i);
            if (i < 32) keep_q.push_back(frame_q[i]);    // 31 in the leaf plus the merge head
        end
        expect_frame(keep_q);
        drive_frame(1'b0);
        for (int c = 0; c < NCH; c++) begin
            check_value($sformatf("drop_count_o[%0d]", c), (c == 0) ? 36'd8 : 36'd0,
                        drop_count_o[c]);
        end
        wait_drained(3000);
        check_value("out_empty_o", 36'd1, {35'd0, out_empty_o});
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+sim
logic/hit_tree_pkg.sv
logic/fifo_buffer.sv
logic/hit_packer.sv
logic/merge_node.sv
logic/hit_tree_top.sv
sim/hit_tree_tb.sv
